//--- src/menu_pkg.sv
`default_nettype none

package menu_pkg;

	// pixel and colour widths
	localparam int PIXEL_W = 11;
	localparam int COLOR_W = 8;

	// menu grid, 64 pixel tiles
	localparam int TILE_SHIFT = 6;
	localparam int GRID_ROWS = 7;
	localparam int GRID_COLS = 10;
	localparam int BUTTON_COL = 5; // column holding the level buttons
	localparam int BUTTON_ROW0 = 1; // first button row

	localparam int NUM_LEVELS = 4;
	localparam int LEVEL_W = 2;

	// tile codes
	localparam int TILE_W = 2;
	localparam logic [TILE_W-1:0] TILE_FREE = 2'd0;
	localparam logic [TILE_W-1:0] TILE_REGU = 2'd1;
	localparam logic [TILE_W-1:0] TILE_SLCT = 2'd2;

	localparam int BORDER_PX = 4; // button frame thickness

	// palette, RRRGGGBB
	localparam logic [COLOR_W-1:0] COLOR_BACK = 8'h02;
	localparam logic [COLOR_W-1:0] COLOR_REGU = 8'h80;
	localparam logic [COLOR_W-1:0] COLOR_SLCT = 8'h10;
	localparam logic [COLOR_W-1:0] COLOR_BORDER = 8'hB6;
	localparam logic [COLOR_W-1:0] COLOR_OVER = 8'hE0;
	localparam logic [COLOR_W-1:0] COLOR_TRANSPARENT = 8'hFF;

	// flat play colour per level, entry 0 is level 0
	localparam logic [NUM_LEVELS-1:0][COLOR_W-1:0] LEVEL_COLOR = {
		8'hE3, // level 3
		8'hFC, // level 2
		8'h1F, // level 1
		8'h1C // level 0
	};

	// round lengths in seconds, level n runs BASE + STEP*n
	localparam int ROUND_BASE_SEC = 3;
	localparam int ROUND_STEP_SEC = 2;
	localparam int OVER_SEC = 2;
	localparam int SEC_W = 4;

	// game states
	localparam int GS_W = 2;
	localparam logic [GS_W-1:0] GS_MENU = 2'd0;
	localparam logic [GS_W-1:0] GS_PLAY = 2'd1;
	localparam logic [GS_W-1:0] GS_OVER = 2'd2;

	localparam int PIPE_LAT = 3; // pixel in to rgb_out

endpackage

`default_nettype wire

//--- src/stage_delay.sv
`default_nettype none

module stage_delay #(
	parameter type payload_t = logic,
	parameter int DEPTH = 1
) (
	input	logic		clk,
	input	logic		resetN,
	input	payload_t	in_data,
	output	payload_t	out_data
);

	payload_t chain [DEPTH];

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			for (int i = 0; i < DEPTH; i++) begin
				chain[i] <= '0;
			end
		end else begin
			chain[0] <= in_data;
			for (int i = 1; i < DEPTH; i++) begin
				chain[i] <= chain[i-1]; // shift one stage
			end
		end
	end

	assign out_data = chain[DEPTH-1];

endmodule

`default_nettype wire

//--- src/menu_screen.sv
`default_nettype none

module menu_screen (
	input	logic				clk,
	input	logic				resetN,
	input	logic [menu_pkg::PIXEL_W-1:0]	pixel_x,
	input	logic [menu_pkg::PIXEL_W-1:0]	pixel_y,
	input	logic				up_keyN,
	input	logic				down_keyN,
	input	logic				select_keyN,
	input	logic				menu_active,
	input	logic				restart,
	output	logic [menu_pkg::TILE_W-1:0]	button_type,
	output	logic [menu_pkg::PIXEL_W-1:0]	tile_top_left_x,
	output	logic [menu_pkg::PIXEL_W-1:0]	tile_top_left_y,
	output	logic				back_request,
	output	logic				menu_done,
	output	logic [menu_pkg::LEVEL_W-1:0]	chosen_level
);

	logic up_key;
	logic down_key;
	logic select_key;
	logic armed; // set once both arrows are released
	logic [menu_pkg::LEVEL_W-1:0] sel;
	logic [menu_pkg::NUM_LEVELS-1:0][menu_pkg::TILE_W-1:0] button_map;

	logic [menu_pkg::PIXEL_W-1:0] tile_col;
	logic [menu_pkg::PIXEL_W-1:0] tile_row;
	logic [menu_pkg::LEVEL_W-1:0] btn_idx;
	logic is_button;
	logic in_grid;

	assign up_key = ~up_keyN;
	assign down_key = ~down_keyN;
	assign select_key = ~select_keyN;

	// one step per press, down wins if both arrows go low together
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			sel <= '0;
			armed <= 1'b1;
		end else if (menu_active && armed && down_key) begin
			armed <= 1'b0;
			if (sel == menu_pkg::LEVEL_W'(menu_pkg::NUM_LEVELS - 1))
				sel <= '0; // wrap to top button
			else
				sel <= sel + 1'b1;
		end else if (menu_active && armed && up_key) begin
			armed <= 1'b0;
			if (sel == '0)
				sel <= menu_pkg::LEVEL_W'(menu_pkg::NUM_LEVELS - 1);
			else
				sel <= sel - 1'b1;
		end else if (!up_key && !down_key) begin
			armed <= 1'b1;
		end
	end

	// level latch, held until the round ends
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			menu_done <= 1'b0;
			chosen_level <= '0;
		end else if (restart) begin
			menu_done <= 1'b0;
		end else if (select_key && menu_active && !menu_done) begin
			menu_done <= 1'b1;
			chosen_level <= sel;
		end
	end

	// button column map, follows sel one edge later
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			for (int i = 0; i < menu_pkg::NUM_LEVELS; i++) begin
				button_map[i] <= (i == 0) ? menu_pkg::TILE_SLCT : menu_pkg::TILE_REGU;
			end
		end else begin
			for (int i = 0; i < menu_pkg::NUM_LEVELS; i++) begin
				if (sel == menu_pkg::LEVEL_W'(i))
					button_map[i] <= menu_pkg::TILE_SLCT;
				else
					button_map[i] <= menu_pkg::TILE_REGU;
			end
		end
	end

	assign tile_col = pixel_x >> menu_pkg::TILE_SHIFT;
	assign tile_row = pixel_y >> menu_pkg::TILE_SHIFT;
	assign btn_idx = menu_pkg::LEVEL_W'(tile_row - menu_pkg::PIXEL_W'(menu_pkg::BUTTON_ROW0));
	assign in_grid = (tile_col < menu_pkg::GRID_COLS) && (tile_row < menu_pkg::GRID_ROWS);
	assign is_button = (tile_col == menu_pkg::BUTTON_COL)
		&& (tile_row >= menu_pkg::BUTTON_ROW0)
		&& (tile_row < menu_pkg::BUTTON_ROW0 + menu_pkg::NUM_LEVELS);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			button_type <= menu_pkg::TILE_FREE;
			back_request <= 1'b0;
		end else begin
			button_type <= is_button ? button_map[btn_idx] : menu_pkg::TILE_FREE;
			back_request <= in_grid; // 640 x 448 menu area
		end
	end

	// tile corner for the painter's in-tile offset
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			tile_top_left_x <= '0;
			tile_top_left_y <= '0;
		end else begin
			tile_top_left_x <= tile_col << menu_pkg::TILE_SHIFT;
			tile_top_left_y <= tile_row << menu_pkg::TILE_SHIFT;
		end
	end

	// a held arrow must not step the selection again
	a_held_key: assert property (@(posedge clk) disable iff (!resetN)
		(!armed && (up_key || down_key)) |=> $stable(sel));

endmodule

`default_nettype wire

//--- src/tile_painter.sv
`default_nettype none

module tile_painter (
	input	logic				clk,
	input	logic				resetN,
	input	logic [menu_pkg::PIXEL_W-1:0]	pixel_x,
	input	logic [menu_pkg::PIXEL_W-1:0]	pixel_y,
	input	logic [menu_pkg::TILE_W-1:0]	button_type,
	input	logic [menu_pkg::PIXEL_W-1:0]	tile_top_left_x,
	input	logic [menu_pkg::PIXEL_W-1:0]	tile_top_left_y,
	output	logic [menu_pkg::COLOR_W-1:0]	tile_color,
	output	logic				tile_request
);

	logic [menu_pkg::PIXEL_W-1:0] off_x;
	logic [menu_pkg::PIXEL_W-1:0] off_y;
	logic on_border;
	logic [menu_pkg::COLOR_W-1:0] next_color;

	// offset inside the 64 x 64 tile
	assign off_x = pixel_x - tile_top_left_x;
	assign off_y = pixel_y - tile_top_left_y;

	assign on_border = (off_x < menu_pkg::BORDER_PX)
		|| (off_x >= (1 << menu_pkg::TILE_SHIFT) - menu_pkg::BORDER_PX)
		|| (off_y < menu_pkg::BORDER_PX)
		|| (off_y >= (1 << menu_pkg::TILE_SHIFT) - menu_pkg::BORDER_PX);

	always_comb begin
		next_color = menu_pkg::COLOR_TRANSPARENT; // free tile
		if (button_type != menu_pkg::TILE_FREE) begin
			if (on_border)
				next_color = menu_pkg::COLOR_BORDER;
			else if (button_type == menu_pkg::TILE_SLCT)
				next_color = menu_pkg::COLOR_SLCT; // highlighted level
			else
				next_color = menu_pkg::COLOR_REGU;
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			tile_color <= menu_pkg::COLOR_TRANSPARENT;
			tile_request <= 1'b0;
		end else begin
			tile_color <= next_color;
			tile_request <= (next_color != menu_pkg::COLOR_TRANSPARENT);
		end
	end

endmodule

`default_nettype wire

//--- src/video_mux.sv
`default_nettype none

module video_mux (
	input	logic				clk,
	input	logic				resetN,
	input	logic [menu_pkg::GS_W-1:0]	game_state,
	input	logic [menu_pkg::LEVEL_W-1:0]	play_level,
	input	logic [menu_pkg::COLOR_W-1:0]	tile_color,
	input	logic				tile_request,
	input	logic				back_request,
	output	logic [menu_pkg::COLOR_W-1:0]	rgb_out
);

	logic [menu_pkg::COLOR_W-1:0] next_rgb;

	always_comb begin
		case (game_state)
			menu_pkg::GS_MENU: begin
				if (tile_request)
					next_rgb = tile_color; // buttons over background
				else if (back_request)
					next_rgb = menu_pkg::COLOR_BACK;
				else
					next_rgb = '0; // outside the grid
			end
			menu_pkg::GS_PLAY: next_rgb = menu_pkg::LEVEL_COLOR[play_level];
			menu_pkg::GS_OVER: next_rgb = menu_pkg::COLOR_OVER;
			default: next_rgb = '0;
		endcase
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			rgb_out <= '0;
		else
			rgb_out <= next_rgb;
	end

endmodule

`default_nettype wire

//--- src/level_timer.sv
`default_nettype none

module level_timer (
	input	logic				clk,
	input	logic				resetN,
	input	logic				on_sec,
	input	logic				timer_load,
	input	logic [menu_pkg::SEC_W-1:0]	load_seconds,
	output	logic [menu_pkg::SEC_W-1:0]	seconds_left,
	output	logic				expired
);

	logic last_sec; // count is about to reach zero

	assign last_sec = (seconds_left == menu_pkg::SEC_W'(1));

	// fires with the strobe that takes the count to zero
	assign expired = on_sec && !timer_load && last_sec;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			seconds_left <= '0;
		end else if (timer_load) begin
			seconds_left <= load_seconds; // load beats the strobe
		end else if (on_sec && (seconds_left != '0)) begin
			seconds_left <= seconds_left - 1'b1;
		end
	end

	// one decrement per second needs a single-cycle strobe
	a_sec_strobe: assert property (@(posedge clk) disable iff (!resetN)
		on_sec |=> !on_sec);

endmodule

`default_nettype wire

//--- src/game_fsm.sv
`default_nettype none

module game_fsm (
	input	logic				clk,
	input	logic				resetN,
	input	logic				menu_done,
	input	logic [menu_pkg::LEVEL_W-1:0]	chosen_level,
	input	logic				expired,
	output	logic [menu_pkg::GS_W-1:0]	game_state,
	output	logic [menu_pkg::LEVEL_W-1:0]	play_level,
	output	logic				timer_load,
	output	logic [menu_pkg::SEC_W-1:0]	load_seconds,
	output	logic				restart,
	output	logic				menu_active
);

	assign menu_active = (game_state == menu_pkg::GS_MENU);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			game_state <= menu_pkg::GS_MENU;
			play_level <= '0;
			timer_load <= 1'b0;
			load_seconds <= '0;
			restart <= 1'b0;
		end else begin
			timer_load <= 1'b0; // strobes
			restart <= 1'b0;
			case (game_state)
				menu_pkg::GS_MENU: begin
					// menu_done is still set in the restart cycle
					if (menu_done && !restart) begin
						game_state <= menu_pkg::GS_PLAY;
						play_level <= chosen_level;
						timer_load <= 1'b1;
						load_seconds <= menu_pkg::SEC_W'(menu_pkg::ROUND_BASE_SEC
							+ menu_pkg::ROUND_STEP_SEC * chosen_level);
					end
				end
				menu_pkg::GS_PLAY: begin
					if (expired) begin
						game_state <= menu_pkg::GS_OVER;
						timer_load <= 1'b1;
						load_seconds <= menu_pkg::SEC_W'(menu_pkg::OVER_SEC);
					end
				end
				menu_pkg::GS_OVER: begin
					if (expired) begin
						game_state <= menu_pkg::GS_MENU;
						restart <= 1'b1; // clears menu_done
					end
				end
				default: game_state <= menu_pkg::GS_MENU;
			endcase
		end
	end

	a_load_single: assert property (@(posedge clk) disable iff (!resetN)
		timer_load |=> !timer_load);

endmodule

`default_nettype wire

//--- src/menu_subsystem.sv
`default_nettype none

module menu_subsystem (
	input	logic				clk,
	input	logic				resetN,
	input	logic [menu_pkg::PIXEL_W-1:0]	pixel_x,
	input	logic [menu_pkg::PIXEL_W-1:0]	pixel_y,
	input	logic				on_sec,
	input	logic				up_keyN,
	input	logic				down_keyN,
	input	logic				select_keyN,
	output	logic [menu_pkg::COLOR_W-1:0]	rgb_out,
	output	logic [menu_pkg::GS_W-1:0]	game_state,
	output	logic [menu_pkg::LEVEL_W-1:0]	play_level,
	output	logic [menu_pkg::SEC_W-1:0]	seconds_left
);

	logic [menu_pkg::TILE_W-1:0] button_type;
	logic [menu_pkg::PIXEL_W-1:0] tile_top_left_x;
	logic [menu_pkg::PIXEL_W-1:0] tile_top_left_y;
	logic back_request;
	logic back_request_d;
	logic [menu_pkg::PIXEL_W-1:0] pixel_x_d;
	logic [menu_pkg::PIXEL_W-1:0] pixel_y_d;
	logic [menu_pkg::COLOR_W-1:0] tile_color;
	logic tile_request;
	logic menu_done;
	logic [menu_pkg::LEVEL_W-1:0] chosen_level;
	logic menu_active;
	logic restart;
	logic timer_load;
	logic [menu_pkg::SEC_W-1:0] load_seconds;
	logic expired;

	menu_screen u_menu_screen (
		.clk(clk), .resetN(resetN), .pixel_x(pixel_x), .pixel_y(pixel_y),
		.up_keyN(up_keyN), .down_keyN(down_keyN), .select_keyN(select_keyN),
		.menu_active(menu_active), .restart(restart), .button_type(button_type),
		.tile_top_left_x(tile_top_left_x), .tile_top_left_y(tile_top_left_y),
		.back_request(back_request), .menu_done(menu_done), .chosen_level(chosen_level)
	);

	// coordinates catch up with the menu_screen register
	stage_delay #(.payload_t(logic [menu_pkg::PIXEL_W-1:0]), .DEPTH(1)) u_dly_x (
		.clk(clk), .resetN(resetN), .in_data(pixel_x), .out_data(pixel_x_d)
	);

	stage_delay #(.payload_t(logic [menu_pkg::PIXEL_W-1:0]), .DEPTH(1)) u_dly_y (
		.clk(clk), .resetN(resetN), .in_data(pixel_y), .out_data(pixel_y_d)
	);

	// background flag skips the painter stage
	stage_delay #(.payload_t(logic), .DEPTH(menu_pkg::PIPE_LAT - 2)) u_dly_back (
		.clk(clk), .resetN(resetN), .in_data(back_request), .out_data(back_request_d)
	);

	tile_painter u_tile_painter (
		.clk(clk), .resetN(resetN), .pixel_x(pixel_x_d), .pixel_y(pixel_y_d),
		.button_type(button_type), .tile_top_left_x(tile_top_left_x),
		.tile_top_left_y(tile_top_left_y), .tile_color(tile_color),
		.tile_request(tile_request)
	);

	video_mux u_video_mux (
		.clk(clk), .resetN(resetN), .game_state(game_state), .play_level(play_level),
		.tile_color(tile_color), .tile_request(tile_request),
		.back_request(back_request_d), .rgb_out(rgb_out)
	);

	game_fsm u_game_fsm (
		.clk(clk), .resetN(resetN), .menu_done(menu_done), .chosen_level(chosen_level),
		.expired(expired), .game_state(game_state), .play_level(play_level),
		.timer_load(timer_load), .load_seconds(load_seconds), .restart(restart),
		.menu_active(menu_active)
	);

	level_timer u_level_timer (
		.clk(clk), .resetN(resetN), .on_sec(on_sec), .timer_load(timer_load),
		.load_seconds(load_seconds), .seconds_left(seconds_left), .expired(expired)
	);

endmodule

`default_nettype wire

//--- tb/menu_checker.sv
`default_nettype none

module menu_checker (
	input	logic				clk,
	input	logic				resetN,
	input	logic [menu_pkg::PIXEL_W-1:0]	pixel_x,
	input	logic [menu_pkg::PIXEL_W-1:0]	pixel_y,
	input	logic				on_sec,
	input	logic				up_keyN,
	input	logic				down_keyN,
	input	logic				select_keyN,
	input	logic [menu_pkg::COLOR_W-1:0]	rgb_out,
	input	logic [menu_pkg::GS_W-1:0]	game_state,
	input	logic [menu_pkg::LEVEL_W-1:0]	play_level,
	input	logic [menu_pkg::SEC_W-1:0]	seconds_left,
	output	int				error_count,
	output	int				check_count
);

	localparam int QUIET_CYCLES = 6; // key to screen is at most 5 edges

	logic [menu_pkg::LEVEL_W-1:0] m_sel;
	logic m_armed;
	logic m_done;
	logic [menu_pkg::LEVEL_W-1:0] m_chosen;
	logic [menu_pkg::GS_W-1:0] m_state;
	logic [menu_pkg::LEVEL_W-1:0] m_level;
	logic m_load;
	logic [menu_pkg::SEC_W-1:0] m_load_val;
	logic m_restart;
	logic [menu_pkg::SEC_W-1:0] m_sec;
	logic [menu_pkg::PIXEL_W-1:0] hist_x [3]; // entry 2 is three cycles old
	logic [menu_pkg::PIXEL_W-1:0] hist_y [3];
	int quiet;

	function automatic logic [menu_pkg::COLOR_W-1:0] expected_color(
		input logic [menu_pkg::PIXEL_W-1:0] x,
		input logic [menu_pkg::PIXEL_W-1:0] y,
		input logic [menu_pkg::GS_W-1:0] state,
		input logic [menu_pkg::LEVEL_W-1:0] level,
		input logic [menu_pkg::LEVEL_W-1:0] sel
	);
		int tile;
		int col;
		int row;
		int ox;
		int oy;
		tile = 1 << menu_pkg::TILE_SHIFT;
		col = x / tile;
		row = y / tile;
		ox = x % tile;
		oy = y % tile;
		if (state == menu_pkg::GS_PLAY)
			return menu_pkg::LEVEL_COLOR[level];
		if (state == menu_pkg::GS_OVER)
			return menu_pkg::COLOR_OVER;
		if (col == menu_pkg::BUTTON_COL && row >= menu_pkg::BUTTON_ROW0
			&& row < menu_pkg::BUTTON_ROW0 + menu_pkg::NUM_LEVELS) begin
			if (ox < menu_pkg::BORDER_PX || oy < menu_pkg::BORDER_PX
				|| ox >= tile - menu_pkg::BORDER_PX || oy >= tile - menu_pkg::BORDER_PX)
				return menu_pkg::COLOR_BORDER;
			if (row - menu_pkg::BUTTON_ROW0 == int'(sel))
				return menu_pkg::COLOR_SLCT;
			return menu_pkg::COLOR_REGU;
		end
		if (col < menu_pkg::GRID_COLS && row < menu_pkg::GRID_ROWS)
			return menu_pkg::COLOR_BACK;
		return '0; // outside the menu area
	endfunction

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Mismatch %s: got %h expected %h at time %0t", name, got, exp, $time);
		end
	endtask

	task automatic reset_model();
		m_sel = '0;
		m_armed = 1'b1;
		m_done = 1'b0;
		m_chosen = '0;
		m_state = menu_pkg::GS_MENU;
		m_level = '0;
		m_load = 1'b0;
		m_load_val = '0;
		m_restart = 1'b0;
		m_sec = '0;
		quiet = QUIET_CYCLES;
		for (int i = 0; i < 3; i++) begin
			hist_x[i] = '0;
			hist_y[i] = '0;
		end
	endtask

	// one clock edge of the game rules, inputs as they will be sampled
	task automatic advance_model();
		logic active;
		logic expired;
		logic old_done;
		logic old_restart;
		logic [menu_pkg::LEVEL_W-1:0] old_sel;
		logic [menu_pkg::LEVEL_W-1:0] old_chosen;
		logic [menu_pkg::GS_W-1:0] old_state;
		active = (m_state == menu_pkg::GS_MENU);
		expired = on_sec && !m_load && (m_sec == 1); // strobe that reaches zero
		old_done = m_done;
		old_restart = m_restart;
		old_sel = m_sel;
		old_chosen = m_chosen;
		old_state = m_state;
		if (m_load)
			m_sec = m_load_val;
		else if (on_sec && m_sec != 0)
			m_sec = m_sec - 1'b1;
		m_load = 1'b0;
		m_restart = 1'b0;
		case (old_state)
			menu_pkg::GS_MENU: begin
				if (old_done && !old_restart) begin
					m_state = menu_pkg::GS_PLAY;
					m_level = old_chosen;
					m_load = 1'b1;
					m_load_val = menu_pkg::SEC_W'(menu_pkg::ROUND_BASE_SEC
						+ menu_pkg::ROUND_STEP_SEC * old_chosen);
				end
			end
			menu_pkg::GS_PLAY: begin
				if (expired) begin
					m_state = menu_pkg::GS_OVER;
					m_load = 1'b1;
					m_load_val = menu_pkg::SEC_W'(menu_pkg::OVER_SEC);
				end
			end
			default: begin
				if (expired) begin
					m_state = menu_pkg::GS_MENU;
					m_restart = 1'b1;
				end
			end
		endcase
		if (old_restart)
			m_done = 1'b0;
		else if (!select_keyN && active && !old_done) begin
			m_done = 1'b1;
			m_chosen = old_sel;
		end
		if (active && m_armed && !down_keyN) begin
			m_armed = 1'b0;
			m_sel = (old_sel == menu_pkg::NUM_LEVELS - 1) ? '0 : old_sel + 1'b1;
		end else if (active && m_armed && !up_keyN) begin
			m_armed = 1'b0;
			m_sel = (old_sel == 0) ? menu_pkg::LEVEL_W'(menu_pkg::NUM_LEVELS - 1) : old_sel - 1'b1;
		end else if (up_keyN && down_keyN) begin
			m_armed = 1'b1; // both arrows released
		end
		if (!up_keyN || !down_keyN || !select_keyN || m_state != old_state)
			quiet = QUIET_CYCLES;
	endtask

	initial begin
		error_count = 0;
		check_count = 0;
	end

	// outputs and inputs are both settled at the falling edge
	always @(negedge clk) begin
		if (!resetN) begin
			reset_model();
		end else begin
			check_value("game_state", 8'(game_state), 8'(m_state));
			check_value("play_level", 8'(play_level), 8'(m_level));
			check_value("seconds_left", 8'(seconds_left), 8'(m_sec));
			if (quiet > 0)
				quiet--;
			else
				check_value("rgb_out", rgb_out,
					expected_color(hist_x[2], hist_y[2], m_state, m_level, m_sel));
			advance_model();
			hist_x[2] = hist_x[1];
			hist_y[2] = hist_y[1];
			hist_x[1] = hist_x[0];
			hist_y[1] = hist_y[0];
			hist_x[0] = pixel_x;
			hist_y[0] = pixel_y;
		end
	end

endmodule

`default_nettype wire

//--- tb/tb_menu_subsystem.sv
`default_nettype none

module tb_menu_subsystem;

	localparam int TEST_CYCLES = 2000; // all tests below take about 1300 cycles
	localparam int TIMEOUT_CYCLES = 10 * TEST_CYCLES;
	localparam int SEC_GAP = 19; // cycles between one-second strobes
	localparam int KEY_UP = 0;
	localparam int KEY_DOWN = 1;
	localparam int KEY_SELECT = 2;

	logic clk;
	logic resetN;
	logic [menu_pkg::PIXEL_W-1:0] pixel_x;
	logic [menu_pkg::PIXEL_W-1:0] pixel_y;
	logic on_sec;
	logic up_keyN;
	logic down_keyN;
	logic select_keyN;
	logic [menu_pkg::COLOR_W-1:0] rgb_out;
	logic [menu_pkg::GS_W-1:0] game_state;
	logic [menu_pkg::LEVEL_W-1:0] play_level;
	logic [menu_pkg::SEC_W-1:0] seconds_left;
	int chk_errors;
	int chk_checks;
	int stim_errors;
	int cycle_count;

	menu_subsystem dut (
		.clk(clk), .resetN(resetN), .pixel_x(pixel_x), .pixel_y(pixel_y), .on_sec(on_sec),
		.up_keyN(up_keyN), .down_keyN(down_keyN), .select_keyN(select_keyN),
		.rgb_out(rgb_out), .game_state(game_state), .play_level(play_level),
		.seconds_left(seconds_left)
	);

	menu_checker u_checker (
		.clk(clk), .resetN(resetN), .pixel_x(pixel_x), .pixel_y(pixel_y), .on_sec(on_sec),
		.up_keyN(up_keyN), .down_keyN(down_keyN), .select_keyN(select_keyN),
		.rgb_out(rgb_out), .game_state(game_state), .play_level(play_level),
		.seconds_left(seconds_left), .error_count(chk_errors), .check_count(chk_checks)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// every cycle gets a new random pixel
	task automatic next_cycle();
		@(posedge clk);
		#1;
		if ($urandom % 2) begin // half of them land on the button column
			pixel_x = menu_pkg::PIXEL_W'(menu_pkg::BUTTON_COL * 64 + $urandom % 64);
			pixel_y = menu_pkg::PIXEL_W'(64 + $urandom % 256);
		end else begin
			pixel_x = menu_pkg::PIXEL_W'($urandom % 800);
			pixel_y = menu_pkg::PIXEL_W'($urandom % 600);
		end
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) next_cycle();
	endtask

	task automatic press_key(input int which, input int hold);
		next_cycle();
		case (which)
			KEY_UP: up_keyN = 1'b0;
			KEY_DOWN: down_keyN = 1'b0;
			default: select_keyN = 1'b0;
		endcase
		repeat (hold) next_cycle();
		up_keyN = 1'b1;
		down_keyN = 1'b1;
		select_keyN = 1'b1;
	endtask

	task automatic step_key(input int which);
		press_key(which, 8); // held long, must still step once
		idle(30);
	endtask

	task automatic wait_for_state(input logic [menu_pkg::GS_W-1:0] target);
		int waited;
		waited = 0;
		while (game_state !== target && waited < 50) begin
			next_cycle();
			waited++;
		end
		if (game_state !== target) begin
			stim_errors++;
			$display("game_state never reached %0d after select", target);
		end
	endtask

	// strobes until the state moves on, then compare with the round length
	task automatic count_strobes(input logic [menu_pkg::GS_W-1:0] phase, input int expected);
		int strobes;
		strobes = 0;
		while (game_state === phase && strobes < 16) begin
			next_cycle();
			on_sec = 1'b1;
			next_cycle();
			on_sec = 1'b0;
			strobes++;
			idle(SEC_GAP);
		end
		if (strobes != expected) begin
			stim_errors++;
			$display("state %0d lasted %0d strobes instead of %0d", phase, strobes, expected);
		end
	endtask

	task automatic play_round(input int level);
		press_key(KEY_SELECT, 3);
		wait_for_state(menu_pkg::GS_PLAY);
		idle(5);
		press_key(KEY_DOWN, 8); // ignored outside the menu
		idle(10);
		press_key(KEY_UP, 8);
		idle(10);
		count_strobes(menu_pkg::GS_PLAY, menu_pkg::ROUND_BASE_SEC + menu_pkg::ROUND_STEP_SEC * level);
		count_strobes(menu_pkg::GS_OVER, menu_pkg::OVER_SEC);
		idle(100); // back in the menu, highlight kept
	endtask

	task automatic print_counts();
		$display("checks %0d, errors %0d (checker %0d, stimulus %0d)",
			chk_checks, chk_errors + stim_errors, chk_errors, stim_errors);
	endtask

	initial begin
		void'($urandom(32'hdb834412));
		stim_errors = 0;
		resetN = 1'b0;
		pixel_x = '0;
		pixel_y = '0;
		on_sec = 1'b0;
		up_keyN = 1'b1;
		down_keyN = 1'b1;
		select_keyN = 1'b1;
		repeat (4) next_cycle();
		resetN = 1'b1;
		idle(200);
		repeat (3) step_key(KEY_DOWN);
		repeat (5) step_key(KEY_UP); // ends on level 2
		play_round(2);
		step_key(KEY_UP);
		play_round(1);
		print_counts();
		if (chk_errors + stim_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
		print_counts();
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- menu_subsystem.f
src/menu_pkg.sv
src/stage_delay.sv
src/menu_screen.sv
src/tile_painter.sv
src/video_mux.sv
src/level_timer.sv
src/game_fsm.sv
src/menu_subsystem.sv
tb/menu_checker.sv
tb/tb_menu_subsystem.sv
